//--- dv/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_core_tb;
  import ooo_pkg::*;

  typedef struct packed {
    issue_t     instr;
    logic [3:0] gap;
  } row_t;

  logic     clk_in;
  logic     rst_in;
  logic     issue_valid;
  issue_t   issue_instr;
  logic     issue_ready;
  logic     commit_valid;
  commit_t  commit_data;

  row_t     row_q [$];
  commit_t  expect_q [$];
  word_t    shadow_regs [`NUM_REGS];
  commit_t  expected;
  integer   seed;
  int       errors;
  int       checked;
  int       outstanding;
  int       alloc_count;
  int       cycle;
  int       first_accept;
  logic     accepted;
  logic     saw_full;
  logic     table_built;

  ooo_core_top i_ooo_core_top (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .issue_valid  (issue_valid),
    .issue_instr  (issue_instr),
    .issue_ready  (issue_ready),
    .commit_valid (commit_valid),
    .commit_data  (commit_data)
  );

  always #5 clk_in = ~clk_in;

  task automatic add_row(input op_t op, input reg_ix_t rd, input reg_ix_t rs1,
                         input reg_ix_t rs2, input word_t imm, input int gap);
    row_t row;
    row.instr.op  = op;
    row.instr.rd  = rd;
    row.instr.rs1 = rs1;
    row.instr.rs2 = rs2;
    row.instr.imm = imm;
    row.gap       = gap[3:0];
    row_q.push_back(row);
  endtask

  // In-order reference on the shadow registers
  function automatic word_t reference_result(input issue_t ins);
    word_t a;
    word_t b;
    a = shadow_regs[ins.rs1];
    b = shadow_regs[ins.rs2];
    case (ins.op)
      `OP_ADD: return a + b;
      `OP_SUB: return a - b;
      `OP_AND: return a & b;
      `OP_XOR: return a ^ b;
      `OP_LI:  return ins.imm;
      `OP_MUL: return a * b;
      default: return '0;
    endcase
  endfunction

  task automatic build_table();
    // Every opcode on settled sources
    add_row(`OP_LI, 1, 0, 0, 32'd5, 0);
    add_row(`OP_LI, 2, 0, 0, 32'd12, 0);
    add_row(`OP_LI, 3, 0, 0, 32'hf0f0_00ff, 8);
    add_row(`OP_ADD, 4, 1, 2, 0, 0);
    add_row(`OP_SUB, 5, 2, 1, 0, 0);
    add_row(`OP_AND, 6, 3, 2, 0, 0);
    add_row(`OP_XOR, 7, 3, 1, 0, 0);
    add_row(`OP_MUL, 0, 1, 2, 0, 8);
    // RAW chains, gap 1 meets the CDB, gap 2 reads a done ROB entry
    add_row(`OP_LI, 1, 0, 0, 32'd7, 0);
    add_row(`OP_ADD, 2, 1, 1, 0, 0);
    add_row(`OP_ADD, 3, 2, 1, 0, 0);
    add_row(`OP_SUB, 4, 3, 2, 0, 2);
    add_row(`OP_ADD, 5, 4, 4, 0, 0);
    add_row(`OP_LI, 6, 0, 0, 32'h1234, 1);
    add_row(`OP_ADD, 7, 6, 5, 0, 2);
    add_row(`OP_LI, 1, 0, 0, 32'd3, 2);
    add_row(`OP_SUB, 2, 1, 7, 0, 4);
    // Several writes to r3 ahead of its readers
    add_row(`OP_LI, 3, 0, 0, 32'd1, 0);
    add_row(`OP_LI, 3, 0, 0, 32'd2, 0);
    add_row(`OP_ADD, 3, 3, 3, 0, 0);
    add_row(`OP_LI, 3, 0, 0, 32'd9, 0);
    add_row(`OP_AND, 4, 3, 3, 0, 0);
    add_row(`OP_XOR, 5, 3, 4, 0, 3);
    add_row(`OP_ADD, 6, 3, 5, 0, 6);
    // Dependent multiplies then back-to-back issue to fill the ROB
    add_row(`OP_LI, 1, 0, 0, 32'd3, 0);
    add_row(`OP_LI, 2, 0, 0, 32'd5, 0);
    for (int i = 0; i < 6; i++) begin
      add_row(`OP_MUL, 1, 1, 2, 0, 0);
    end
    add_row(`OP_ADD, 3, 1, 2, 0, 0);
    add_row(`OP_ADD, 4, 2, 2, 0, 0);
    add_row(`OP_XOR, 5, 4, 2, 0, 0);
    add_row(`OP_SUB, 6, 2, 4, 0, 0);
    add_row(`OP_AND, 7, 6, 5, 0, 0);
    add_row(`OP_LI, 0, 0, 0, 32'h77, 0);
    add_row(`OP_ADD, 0, 0, 2, 0, 0);
    add_row(`OP_SUB, 3, 0, 4, 0, 10);
    // Mixed random section
    for (int i = 0; i < 60; i++) begin
      add_row(op_t'({$random(seed)} % 6), reg_ix_t'($random(seed)), reg_ix_t'($random(seed)),
              reg_ix_t'($random(seed)), word_t'($random(seed)), {$random(seed)} % 3);
    end
    // Read every register back through the core
    for (int i = 0; i < `NUM_REGS; i++) begin
      add_row(`OP_AND, reg_ix_t'(i), reg_ix_t'(i), reg_ix_t'(i), 0, 0);
    end
  endtask

  // Commit checker and reference model, on the falling edge
  always @(negedge clk_in) begin
    if (!rst_in) begin
      cycle++;
      accepted = issue_valid && issue_ready;
      assert (issue_ready == (outstanding < `ROB_DEPTH)) else begin
        errors++;
        $display("CHECK FAILED at %0t: issue_ready expected %0b, got %0b", $time,
                 outstanding < `ROB_DEPTH, issue_ready);
      end
      if (!issue_ready) begin
        saw_full = 1'b1;
      end
      if (commit_valid && (expect_q.size() == 0)) begin
        errors++;
        $display("ERROR at %0t: commit seen with no instruction outstanding", $time);
      end else if (commit_valid) begin
        expected = expect_q.pop_front();
        outstanding--;
        checked++;
        if (checked == 1) begin
          // Lone independent instruction commits three cycles after acceptance
          assert (cycle - first_accept == 3) else begin
            errors++;
            $display("CHECK FAILED at %0t: commit latency expected 3, got %0d", $time,
                     cycle - first_accept);
          end
        end
        assert (commit_data.rd == expected.rd) else begin
          errors++;
          $display("CHECK FAILED at %0t: commit_data.rd expected %0d, got %0d", $time,
                   expected.rd, commit_data.rd);
        end
        assert (commit_data.value == expected.value) else begin
          errors++;
          $display("CHECK FAILED at %0t: commit_data.value expected %h, got %h", $time,
                   expected.value, commit_data.value);
        end
        assert (commit_data.tag == expected.tag) else begin
          errors++;
          $display("CHECK FAILED at %0t: commit_data.tag expected %0d, got %0d", $time,
                   expected.tag, commit_data.tag);
        end
      end
      if (accepted) begin
        if (first_accept < 0) begin
          first_accept = cycle;
        end
        expected.rd    = issue_instr.rd;
        expected.value = reference_result(issue_instr);
        // ROB slots are handed out in order from slot 0 after reset
        expected.tag   = rob_ix_t'(alloc_count % `ROB_DEPTH);
        alloc_count++;
        shadow_regs[issue_instr.rd] = expected.value;
        expect_q.push_back(expected);
        outstanding++;
      end
      assert (outstanding <= `ROB_DEPTH) else begin
        errors++;
        $display("ERROR at %0t: %0d instructions outstanding, more than the ROB holds",
                 $time, outstanding);
      end
    end
  end

  // Watchdog scaled by the table length
  initial begin
    wait (table_built);
    #(row_q.size() * (`MUL_CYCLES + `ROB_DEPTH) * 10 + 2000);
    $display("Timeout: the run did not finish in the expected time");
    $display("Checks failed");
    $finish;
  end

  initial begin
    clk_in       = 1'b0;
    rst_in       = 1'b1;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    seed         = 43;
    errors       = 0;
    checked      = 0;
    outstanding  = 0;
    alloc_count  = 0;
    cycle        = 0;
    first_accept = -1;
    saw_full     = 1'b0;
    table_built  = 1'b0;
    for (int i = 0; i < `NUM_REGS; i++) begin
      shadow_regs[i] = '0;
    end
    build_table();
    table_built = 1'b1;

    repeat (16) @(posedge clk_in);
    rst_in <= 1'b0;
    repeat (3) @(negedge clk_in);
    assert (issue_ready) else begin
      errors++;
      $display("CHECK FAILED at %0t: issue_ready expected 1, got %0b", $time, issue_ready);
    end
    assert (!commit_valid) else begin
      errors++;
      $display("CHECK FAILED at %0t: commit_valid expected 0, got %0b", $time, commit_valid);
    end

    @(posedge clk_in);
    foreach (row_q[i]) begin
      issue_valid <= 1'b1;
      issue_instr <= row_q[i].instr;
      @(negedge clk_in);
      while (!issue_ready) begin
        @(negedge clk_in);
      end
      @(posedge clk_in);
      if (row_q[i].gap != 0) begin
        issue_valid <= 1'b0;
        repeat (row_q[i].gap) @(posedge clk_in);
      end
    end
    issue_valid <= 1'b0;

    // Drain what is still in flight
    for (int n = 0; (n < 200) && (expect_q.size() != 0); n++) begin
      @(posedge clk_in);
    end
    repeat (4) @(posedge clk_in);
    assert (expect_q.size() == 0) else begin
      errors++;
      $display("ERROR: %0d accepted instructions never committed", expect_q.size());
    end
    if (!saw_full) begin
      errors++;
      $display("ERROR: issue_ready never dropped with the reorder buffer full");
    end

    $display("Run finished with %0d errors over %0d commits", errors, checked);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- ooo_core_top.f
+incdir+source
source/ooo_pkg.sv
source/reorder_buffer.sv
source/register_alias_file.sv
source/dispatch_stage.sv
source/exec_cluster.sv
source/ooo_core_top.sv
dv/ooo_core_tb.sv

//--- source/dispatch_stage.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module dispatch_stage (
  input  logic               issue_valid,
  input  ooo_pkg::issue_t    issue_instr,
  input  logic               space_avail,
  output logic               issue_ready,
  output ooo_pkg::reg_ix_t   rs1,
  output ooo_pkg::reg_ix_t   rs2,
  input  ooo_pkg::word_t     rs1_value,
  input  ooo_pkg::word_t     rs2_value,
  input  logic               rs1_busy,
  input  logic               rs2_busy,
  input  ooo_pkg::rob_ix_t   rs1_tag,
  input  ooo_pkg::rob_ix_t   rs2_tag,
  output ooo_pkg::rob_ix_t   lookup1_ix,
  output ooo_pkg::rob_ix_t   lookup2_ix,
  input  ooo_pkg::word_t     lookup1_value,
  input  ooo_pkg::word_t     lookup2_value,
  input  logic               lookup1_done,
  input  logic               lookup2_done,
  input  ooo_pkg::rob_ix_t   tail_ix,
  output logic               alloc,
  output logic               rename_valid,
  output ooo_pkg::reg_ix_t   rename_rd,
  output ooo_pkg::rob_ix_t   rename_tag,
  output logic               rs_push,
  output ooo_pkg::dispatch_t rs_entry
);
  import ooo_pkg::*;

  logic     accept;
  operand_t src1;
  operand_t src2;

  // Register file first, then a finished ROB entry, else wait on the tag
  function automatic operand_t resolve(input logic    busy,
                                       input word_t   arf_value,
                                       input rob_ix_t src_tag,
                                       input logic    rob_done,
                                       input word_t   rob_value);
    operand_t res;
    res.tag   = src_tag;
    res.ready = !busy || rob_done;
    res.value = busy ? rob_value : arf_value;
    return res;
  endfunction

  assign issue_ready = space_avail;
  assign accept      = issue_valid && space_avail;

  assign alloc        = accept;
  assign rename_valid = accept;
  assign rs_push      = accept;
  assign rename_rd    = issue_instr.rd;
  assign rename_tag   = tail_ix;

  assign rs1        = issue_instr.rs1;
  assign rs2        = issue_instr.rs2;
  assign lookup1_ix = rs1_tag;
  assign lookup2_ix = rs2_tag;

  always_comb begin
    src1 = resolve(rs1_busy, rs1_value, rs1_tag, lookup1_done, lookup1_value);
    src2 = resolve(rs2_busy, rs2_value, rs2_tag, lookup2_done, lookup2_value);
    // Load-immediate carries imm in place of rs2
    if (issue_instr.op == `OP_LI) begin
      src2.ready = 1'b1;
      src2.value = issue_instr.imm;
    end
    rs_entry.op   = issue_instr.op;
    rs_entry.dest = tail_ix;
    rs_entry.src1 = src1;
    rs_entry.src2 = src2;
  end

endmodule

//--- source/exec_cluster.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module exec_cluster (
  input  logic               clk_in,
  input  logic               rst_in,
  input  logic               rs_push,
  input  ooo_pkg::dispatch_t rs_entry,
  output ooo_pkg::cdb_t      cdb
);
  import ooo_pkg::*;

  localparam int mul_cnt_w = $clog2(`MUL_CYCLES);

  dispatch_t             station [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] valid;
  // older[i][j] set when slot i was filled before slot j
  logic [`ROB_DEPTH-1:0] older   [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] entry_ready;
  logic [`ROB_DEPTH-1:0] is_oldest;
  rob_ix_t               free_ix;
  rob_ix_t               sel_ix;
  logic                  sel_fire;
  dispatch_t             sel_entry;
  word_t                 alu_result;
  exec_state_t           state;
  logic [mul_cnt_w-1:0]  mul_cnt;
  word_t                 mul_a;
  word_t                 mul_b;
  rob_ix_t               mul_tag;
  logic                  cdb_valid;
  rob_ix_t               cdb_tag;
  word_t                 cdb_value;

  // Operand wakeup from a broadcast
  function automatic operand_t wake(input operand_t opnd, input cdb_t bus);
    operand_t res;
    res = opnd;
    if (!opnd.ready && bus.valid && (bus.tag == opnd.tag)) begin
      res.ready = 1'b1;
      res.value = bus.value;
    end
    return res;
  endfunction

  assign cdb = {cdb_valid, cdb_tag, cdb_value};

  // Oldest ready entry by allocation order
  always_comb begin
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      entry_ready[i] = valid[i] && station[i].src1.ready && station[i].src2.ready;
    end
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      is_oldest[i] = entry_ready[i];
      for (int j = 0; j < `ROB_DEPTH; j++) begin
        if ((j != i) && entry_ready[j] && !older[i][j]) begin
          is_oldest[i] = 1'b0;
        end
      end
    end
    sel_ix = '0;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      if (is_oldest[i]) begin
        sel_ix = rob_ix_t'(i);
      end
    end
  end

  // Lowest empty slot, one always exists when a push arrives
  always_comb begin
    free_ix = '0;
    for (int i = `ROB_DEPTH - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        free_ix = rob_ix_t'(i);
      end
    end
  end

  assign sel_fire  = (|is_oldest) && (state == EXEC_IDLE);
  assign sel_entry = station[sel_ix];

  always_comb begin
    case (sel_entry.op)
      `OP_ADD: alu_result = sel_entry.src1.value + sel_entry.src2.value;
      `OP_SUB: alu_result = sel_entry.src1.value - sel_entry.src2.value;
      `OP_AND: alu_result = sel_entry.src1.value & sel_entry.src2.value;
      `OP_XOR: alu_result = sel_entry.src1.value ^ sel_entry.src2.value;
      `OP_LI:  alu_result = sel_entry.src2.value;
      default: alu_result = '0;
    endcase
  end

  // Station occupancy and age order
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid <= '0;
      for (int i = 0; i < `ROB_DEPTH; i++) begin
        older[i] <= '0;
      end
    end else begin
      if (sel_fire) begin
        valid[sel_ix] <= 1'b0;
      end
      if (rs_push) begin
        valid[free_ix] <= 1'b1;
        // New entry is younger than everything already held
        for (int j = 0; j < `ROB_DEPTH; j++) begin
          older[free_ix][j] <= 1'b0;
          older[j][free_ix] <= (j != free_ix);
        end
      end
    end
  end

  // Entry payload, including wakeup of a push that meets the broadcast
  always_ff @(posedge clk_in) begin
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      station[i].src1 <= wake(station[i].src1, cdb);
      station[i].src2 <= wake(station[i].src2, cdb);
    end
    if (rs_push) begin
      station[free_ix].op   <= rs_entry.op;
      station[free_ix].dest <= rs_entry.dest;
      station[free_ix].src1 <= wake(rs_entry.src1, cdb);
      station[free_ix].src2 <= wake(rs_entry.src2, cdb);
    end
  end

  // Execute FSM, mul_cnt counts the busy cycles left after the select cycle
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state     <= EXEC_IDLE;
      mul_cnt   <= '0;
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= 1'b0;
      case (state)
        EXEC_IDLE: begin
          if (sel_fire && (sel_entry.op == `OP_MUL)) begin
            state   <= EXEC_MUL_BUSY;
            mul_cnt <= mul_cnt_w'(`MUL_CYCLES - 2);
          end else if (sel_fire) begin
            cdb_valid <= 1'b1;
          end
        end
        EXEC_MUL_BUSY: begin
          if (mul_cnt == '0) begin
            state     <= EXEC_IDLE;
            cdb_valid <= 1'b1;
          end else begin
            mul_cnt <= mul_cnt - 1'b1;
          end
        end
        default: state <= EXEC_IDLE;
      endcase
    end
  end

  // Result and multiplier operands
  always_ff @(posedge clk_in) begin
    if (sel_fire) begin
      mul_a     <= sel_entry.src1.value;
      mul_b     <= sel_entry.src2.value;
      mul_tag   <= sel_entry.dest;
      cdb_tag   <= sel_entry.dest;
      cdb_value <= alu_result;
    end else if ((state == EXEC_MUL_BUSY) && (mul_cnt == '0)) begin
      cdb_tag   <= mul_tag;
      cdb_value <= mul_a * mul_b;
    end
  end

endmodule

//--- source/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// Reorder buffer and reservation station depth, must be a power of two
`define ROB_DEPTH  8
`define ROB_PTR_W  3

// Architectural register file
`define NUM_REGS   8
`define REG_IX_W   3

// Multiplier occupancy in cycles
`define MUL_CYCLES 4

// Operation codes
`define OP_ADD     3'd0
`define OP_SUB     3'd1
`define OP_AND     3'd2
`define OP_XOR     3'd3
`define OP_LI      3'd4
`define OP_MUL     3'd5

`endif

//--- source/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              issue_valid,
  input  ooo_pkg::issue_t   issue_instr,
  output logic              issue_ready,
  output logic              commit_valid,
  output ooo_pkg::commit_t  commit_data
);
  import ooo_pkg::*;

  // Alias file reads
  reg_ix_t   rs1;
  reg_ix_t   rs2;
  word_t     rs1_value;
  word_t     rs2_value;
  logic      rs1_busy;
  logic      rs2_busy;
  rob_ix_t   rs1_tag;
  rob_ix_t   rs2_tag;

  // Reorder buffer lookups and allocation
  rob_ix_t   lookup1_ix;
  rob_ix_t   lookup2_ix;
  word_t     lookup1_value;
  word_t     lookup2_value;
  logic      lookup1_done;
  logic      lookup2_done;
  rob_ix_t   tail_ix;
  logic      alloc;
  logic      space_avail;

  // Rename, station push and result bus
  logic      rename_valid;
  reg_ix_t   rename_rd;
  rob_ix_t   rename_tag;
  logic      rs_push;
  dispatch_t rs_entry;
  cdb_t      cdb;

  dispatch_stage i_dispatch_stage (
    .issue_valid   (issue_valid),
    .issue_instr   (issue_instr),
    .space_avail   (space_avail),
    .issue_ready   (issue_ready),
    .rs1           (rs1),
    .rs2           (rs2),
    .rs1_value     (rs1_value),
    .rs2_value     (rs2_value),
    .rs1_busy      (rs1_busy),
    .rs2_busy      (rs2_busy),
    .rs1_tag       (rs1_tag),
    .rs2_tag       (rs2_tag),
    .lookup1_ix    (lookup1_ix),
    .lookup2_ix    (lookup2_ix),
    .lookup1_value (lookup1_value),
    .lookup2_value (lookup2_value),
    .lookup1_done  (lookup1_done),
    .lookup2_done  (lookup2_done),
    .tail_ix       (tail_ix),
    .alloc         (alloc),
    .rename_valid  (rename_valid),
    .rename_rd     (rename_rd),
    .rename_tag    (rename_tag),
    .rs_push       (rs_push),
    .rs_entry      (rs_entry)
  );

  register_alias_file i_register_alias_file (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .rs1_busy     (rs1_busy),
    .rs2_busy     (rs2_busy),
    .rs1_tag      (rs1_tag),
    .rs2_tag      (rs2_tag),
    .rename_valid (rename_valid),
    .rename_rd    (rename_rd),
    .rename_tag   (rename_tag),
    .commit_valid (commit_valid),
    .commit_data  (commit_data)
  );

  reorder_buffer i_reorder_buffer (
    .clk_in        (clk_in),
    .rst_in        (rst_in),
    .alloc         (alloc),
    .alloc_data    (issue_instr),
    .tail_ix       (tail_ix),
    .lookup1_ix    (lookup1_ix),
    .lookup2_ix    (lookup2_ix),
    .lookup1_value (lookup1_value),
    .lookup2_value (lookup2_value),
    .lookup1_done  (lookup1_done),
    .lookup2_done  (lookup2_done),
    .cdb           (cdb),
    .space_avail   (space_avail),
    .commit_valid  (commit_valid),
    .commit_data   (commit_data)
  );

  exec_cluster i_exec_cluster (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .rs_push  (rs_push),
    .rs_entry (rs_entry),
    .cdb      (cdb)
  );

endmodule

//--- source/ooo_pkg.sv
`include "ooo_consts.svh"

package ooo_pkg;

  typedef logic [31:0]            word_t;
  typedef logic [`ROB_PTR_W-1:0]  rob_ix_t;
  typedef logic [`REG_IX_W-1:0]   reg_ix_t;
  typedef logic [2:0]             op_t;

  // Decoded instruction at the core boundary
  typedef struct packed {
    op_t     op;
    reg_ix_t rd;
    reg_ix_t rs1;
    reg_ix_t rs2;
    word_t   imm;
  } issue_t;

  // Source operand, tag only meaningful while not ready
  typedef struct packed {
    logic    ready;
    word_t   value;
    rob_ix_t tag;
  } operand_t;

  // Reservation station entry
  typedef struct packed {
    op_t      op;
    rob_ix_t  dest;
    operand_t src1;
    operand_t src2;
  } dispatch_t;

  // Common data bus broadcast
  typedef struct packed {
    logic    valid;
    rob_ix_t tag;
    word_t   value;
  } cdb_t;

  // Retired instruction
  typedef struct packed {
    reg_ix_t rd;
    word_t   value;
    rob_ix_t tag;
  } commit_t;

  typedef enum logic {
    EXEC_IDLE,
    EXEC_MUL_BUSY
  } exec_state_t;

endpackage

//--- source/register_alias_file.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module register_alias_file (
  input  logic              clk_in,
  input  logic              rst_in,
  input  ooo_pkg::reg_ix_t  rs1,
  input  ooo_pkg::reg_ix_t  rs2,
  output ooo_pkg::word_t    rs1_value,
  output ooo_pkg::word_t    rs2_value,
  output logic              rs1_busy,
  output logic              rs2_busy,
  output ooo_pkg::rob_ix_t  rs1_tag,
  output ooo_pkg::rob_ix_t  rs2_tag,
  input  logic              rename_valid,
  input  ooo_pkg::reg_ix_t  rename_rd,
  input  ooo_pkg::rob_ix_t  rename_tag,
  input  logic              commit_valid,
  input  ooo_pkg::commit_t  commit_data
);
  import ooo_pkg::*;

  word_t                 arch_value [`NUM_REGS];
  logic [`NUM_REGS-1:0]  busy;
  rob_ix_t               tag        [`NUM_REGS];
  logic                  clear_busy;

  // Combinational read ports
  assign rs1_value = arch_value[rs1];
  assign rs1_busy  = busy[rs1];
  assign rs1_tag   = tag[rs1];
  assign rs2_value = arch_value[rs2];
  assign rs2_busy  = busy[rs2];
  assign rs2_tag   = tag[rs2];

  // Only the newest producer may release the register
  assign clear_busy = commit_valid
                   && (tag[commit_data.rd] == commit_data.tag)
                   && !(rename_valid && (rename_rd == commit_data.rd));

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= '0;
      for (int i = 0; i < `NUM_REGS; i++) begin
        arch_value[i] <= '0;
      end
    end else begin
      if (commit_valid) begin
        arch_value[commit_data.rd] <= commit_data.value;
      end
      if (clear_busy) begin
        busy[commit_data.rd] <= 1'b0;
      end
      if (rename_valid) begin
        busy[rename_rd] <= 1'b1;
      end
    end
  end

  // Tags are ignored while busy is clear
  always_ff @(posedge clk_in) begin
    if (rename_valid) begin
      tag[rename_rd] <= rename_tag;
    end
  end

endmodule

//--- source/reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module reorder_buffer (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              alloc,
  input  ooo_pkg::issue_t   alloc_data,
  output ooo_pkg::rob_ix_t  tail_ix,
  input  ooo_pkg::rob_ix_t  lookup1_ix,
  input  ooo_pkg::rob_ix_t  lookup2_ix,
  output ooo_pkg::word_t    lookup1_value,
  output ooo_pkg::word_t    lookup2_value,
  output logic              lookup1_done,
  output logic              lookup2_done,
  input  ooo_pkg::cdb_t     cdb,
  output logic              space_avail,
  output logic              commit_valid,
  output ooo_pkg::commit_t  commit_data
);
  import ooo_pkg::*;

  // Extra MSB on each pointer tells full from empty
  logic [`ROB_PTR_W:0]   head_ptr;
  logic [`ROB_PTR_W:0]   tail_ptr;
  rob_ix_t               head_ix;
  logic                  empty;
  logic                  full;

  // Per-entry state
  reg_ix_t               rd_mem    [`ROB_DEPTH];
  word_t                 value_mem [`ROB_DEPTH];
  logic [`ROB_DEPTH-1:0] done;

  assign head_ix = head_ptr[`ROB_PTR_W-1:0];
  assign tail_ix = tail_ptr[`ROB_PTR_W-1:0];

  assign empty = (head_ptr == tail_ptr);
  assign full  = (head_ptr[`ROB_PTR_W] != tail_ptr[`ROB_PTR_W]) && (head_ix == tail_ix);

  assign space_avail = !full;

  // Operand lookups for the dispatch stage
  assign lookup1_value = value_mem[lookup1_ix];
  assign lookup1_done  = done[lookup1_ix];
  assign lookup2_value = value_mem[lookup2_ix];
  assign lookup2_done  = done[lookup2_ix];

  // Head retires as soon as its result is in
  assign commit_valid = !empty && done[head_ix];

  always_comb begin
    commit_data.rd    = rd_mem[head_ix];
    commit_data.value = value_mem[head_ix];
    commit_data.tag   = head_ix;
  end

  // Pointers and completion flags
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      done     <= '0;
    end else begin
      if (alloc) begin
        done[tail_ix] <= 1'b0;
        tail_ptr      <= tail_ptr + 1'b1;
      end
      // Alloc never targets an in-flight tag, so no conflict here
      if (cdb.valid) begin
        done[cdb.tag] <= 1'b1;
      end
      if (commit_valid) begin
        head_ptr <= head_ptr + 1'b1;
      end
    end
  end

  // Destination register and result storage
  always_ff @(posedge clk_in) begin
    if (alloc) begin
      rd_mem[tail_ix] <= alloc_data.rd;
    end
    if (cdb.valid) begin
      value_mem[cdb.tag] <= cdb.value;
    end
  end

endmodule
